//--- hdl/rxdma_pkg.sv
//////////////////////////////////////////////////////////////////////
// Sizes and register codes for the receive DMA engine.
// Data moves in 16-byte words; the local ring FIFO is 64 KiB.
// A register write word is read as a page or as config fields.
//////////////////////////////////////////////////////////////////////
package rxdma_pkg;

    localparam integer WORD_BYTES_LOG = 4;                 // 16-byte data word

    localparam integer BUF_IDX_W   = 5;                    // 32 host buffers
    localparam integer BUF_CNT_W   = BUF_IDX_W + 1;        // Ring counter with wrap bit
    localparam integer LADDR_W     = 16 - WORD_BYTES_LOG;  // 64 KiB FIFO in words
    localparam integer RADDR_W     = 32 - WORD_BYTES_LOG;  // Host word address
    localparam integer PAGE_W      = 20;                   // Host address bits 31:12
    localparam integer BURST_W     = 12;                   // Burst size in words
    localparam integer BPB_W       = 5;                    // Bursts per buffer minus one
    localparam integer LEN_W       = 6;                    // Request words minus one
    localparam integer BUF_WORDS_W = 17;                   // Words in one buffer

    // Register group codes, taken from reg_addr[7:5]
    localparam logic [2:0] REG_ADDR_TBL = 3'd0;
    localparam logic [2:0] REG_BURST    = 3'd1;
    localparam logic [2:0] REG_BPB      = 3'd2;

    // Write word decoded per group code
    // Config burst words sit in bits 11:0 and bursts per buffer minus one in 16:12
    typedef union packed {
        struct packed {
            logic [PAGE_W-1:0]    num;     // Page number of the host buffer
            logic [31-PAGE_W:0]   unused;  // Offset within the 4 KiB page
        } page;
        struct packed {
            logic [31-BPB_W-BURST_W:0] rsvd;
            logic [BPB_W-1:0]          bpb;
            logic [BURST_W-1:0]        burst_words;
        } cfg;
    } rxdma_wdata_u;

endpackage

//--- hdl/rxdma_reg_decode.sv
//////////////////////////////////////////////////////////////////////
// Register and command decode. Config writes are taken at any
// time but must only be issued while the DMA is stopped.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rxdma_reg_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             reg_valid,
    input  logic [7:0]                       reg_addr,
    input  rxdma_pkg::rxdma_wdata_u          reg_wdata,
    input  logic                             ctrl_valid,
    input  logic                             ctrl_start,
    output logic                             dma_en,
    output logic [rxdma_pkg::BURST_W-1:0]    burst_words,
    output logic [rxdma_pkg::BPB_W-1:0]      bufs_bursts,
    output logic                             tbl_we,
    output logic [rxdma_pkg::BUF_IDX_W-1:0]  tbl_idx,
    output logic [rxdma_pkg::PAGE_W-1:0]     tbl_page
);
    import rxdma_pkg::*;

    logic [2:0] grp;

    assign grp = reg_addr[7:5];

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_en <= 1'b0;
            tbl_we <= 1'b0;
        end else begin
            tbl_we <= reg_valid && (grp == REG_ADDR_TBL);
            if (ctrl_valid) begin
                dma_en <= ctrl_start;  // Start sets, stop clears
            end
        end
    end

    // Pick the union member that matches the group
    always_ff @(posedge clk) begin
        if (reg_valid) begin
            case (grp)
                REG_ADDR_TBL: begin
                    tbl_idx  <= reg_addr[BUF_IDX_W-1:0];
                    tbl_page <= reg_wdata.page.num;
                end
                REG_BURST: burst_words <= reg_wdata.cfg.burst_words;
                REG_BPB:   bufs_bursts <= reg_wdata.cfg.bpb;
                default: ;  // Unmapped groups are ignored
            endcase
        end
    end

endmodule

//--- hdl/rxdma_buf_ring.sv
//////////////////////////////////////////////////////////////////////
// Host buffer ring. Counters run from zero while enabled and clear
// when the DMA is stopped; the address table keeps its contents.
// A buffer counts as complete once its last burst has been filled.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rxdma_buf_ring (
    input  logic                               clk,
    input  logic                               dma_en,
    input  logic [rxdma_pkg::BURST_W-1:0]      burst_words,
    input  logic [rxdma_pkg::BPB_W-1:0]        bufs_bursts,
    input  logic                               tbl_we,
    input  logic [rxdma_pkg::BUF_IDX_W-1:0]    tbl_idx,
    input  logic [rxdma_pkg::PAGE_W-1:0]       tbl_page,
    input  logic                               burst_fill,
    input  logic                               buf_done,
    input  logic                               confirm_valid,
    output logic [rxdma_pkg::BUF_WORDS_W-1:0]  avail_words,
    output logic                               buf_complete,
    output logic                               host_free,
    output logic [rxdma_pkg::PAGE_W-1:0]       cur_page
);
    import rxdma_pkg::*;

    logic [PAGE_W-1:0]    addr_tbl [2**BUF_IDX_W];
    logic [BUF_CNT_W-1:0] cnt_inram;      // Buffers fully filled in the FIFO
    logic [BUF_CNT_W-1:0] cnt_xfred;      // Buffers sent to the host
    logic [BUF_CNT_W-1:0] cnt_confirmed;  // Buffers handed back by the host
    logic [BUF_CNT_W-1:0] host_held;
    logic [BPB_W-1:0]     fill_bursts;    // Bursts in the buffer being filled
    logic [BPB_W:0]       bursts_seen;

    always_ff @(posedge clk) begin
        if (tbl_we) begin
            addr_tbl[tbl_idx] <= tbl_page;
        end
    end

    assign cur_page = addr_tbl[cnt_xfred[BUF_IDX_W-1:0]];

    // Transfer buffer is complete when the fill side is ahead of it
    assign buf_complete = (cnt_inram != cnt_xfred);
    assign bursts_seen  = buf_complete ? {1'b0, bufs_bursts} + 1'b1 : {1'b0, fill_bursts};
    assign avail_words  = BUF_WORDS_W'(bursts_seen) * BUF_WORDS_W'(burst_words);

    assign host_held = cnt_xfred - cnt_confirmed;
    assign host_free = !host_held[BUF_CNT_W-1];  // Fewer than 32 held by host

    always_ff @(posedge clk) begin
        if (!dma_en) begin
            cnt_inram     <= '0;
            cnt_xfred     <= '0;
            cnt_confirmed <= '0;
            fill_bursts   <= '0;
        end else begin
            if (burst_fill) begin
                if (fill_bursts == bufs_bursts) begin
                    fill_bursts <= '0;
                    cnt_inram   <= cnt_inram + 1'b1;
                end else begin
                    fill_bursts <= fill_bursts + 1'b1;
                end
            end
            if (buf_done) begin
                cnt_xfred <= cnt_xfred + 1'b1;
            end
            if (confirm_valid) begin
                cnt_confirmed <= cnt_confirmed + 1'b1;
            end
        end
    end

endmodule

//--- hdl/rxdma_req_engine.sv
//////////////////////////////////////////////////////////////////////
// Splits the transfer buffer into write requests of at most one
// max payload. Only one request is outstanding; the host must
// accept every request and complete them in order.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rxdma_req_engine (
    input  logic                               clk,
    input  logic                               dma_en,
    input  logic [1:0]                         cfg_max_payload_sz,
    input  logic [rxdma_pkg::BUF_WORDS_W-1:0]  avail_words,
    input  logic                               buf_complete,
    input  logic                               host_free,
    input  logic [rxdma_pkg::PAGE_W-1:0]       cur_page,
    input  logic                               cpl_valid,
    output logic                               req_valid,
    output logic [rxdma_pkg::LADDR_W-1:0]      req_laddr,
    output logic [rxdma_pkg::RADDR_W-1:0]      req_raddr,
    output logic [rxdma_pkg::LEN_W-1:0]        req_len,
    output logic                               buf_done
);
    import rxdma_pkg::*;

    logic [BUF_WORDS_W-1:0] sent_words;  // Words requested from this buffer
    logic [LADDR_W-1:0]     laddr_nxt;
    logic [RADDR_W-1:0]     raddr_nxt;
    logic                   busy;        // Request outstanding
    logic                   busy_last;   // It closes the buffer
    logic [LEN_W:0]         max_words;
    logic [BUF_WORDS_W-1:0] max_ext;
    logic [BUF_WORDS_W-1:0] unsent;
    logic                   full_ok;
    logic                   last_chunk;
    logic                   issue;
    logic [LEN_W:0]         chunk;
    logic [LEN_W:0]         chunk_m1;
    logic [RADDR_W-1:0]     raddr_cur;

    assign max_words = (LEN_W+1)'(8) << cfg_max_payload_sz;  // 8, 16, 32 or 64 words
    assign max_ext   = BUF_WORDS_W'(max_words);
    assign unsent    = avail_words - sent_words;
    assign full_ok   = (unsent >= max_ext);

    // Final words of a buffer only show up once it is complete
    assign last_chunk = buf_complete && (unsent <= max_ext);
    assign issue      = dma_en && !busy && host_free &&
                        (full_ok || (buf_complete && (unsent != '0)));

    assign chunk    = full_ok ? max_words : unsent[LEN_W:0];
    assign chunk_m1 = chunk - 1'b1;

    // First chunk starts at the page base of the table entry
    assign raddr_cur = (sent_words == '0) ?
                       {cur_page, {(RADDR_W-PAGE_W){1'b0}}} : raddr_nxt;

    assign buf_done = busy && busy_last && cpl_valid;

    always_ff @(posedge clk) begin
        req_valid <= issue;
        if (!dma_en) begin
            sent_words <= '0;
            laddr_nxt  <= '0;
            busy       <= 1'b0;
            busy_last  <= 1'b0;
        end else begin
            if (issue) begin
                sent_words <= sent_words + BUF_WORDS_W'(chunk);
                laddr_nxt  <= laddr_nxt + LADDR_W'(chunk);  // Wraps at FIFO end
                raddr_nxt  <= raddr_cur + RADDR_W'(chunk);
                busy       <= 1'b1;
                busy_last  <= last_chunk;
            end else if (cpl_valid) begin
                busy <= 1'b0;
            end
            if (buf_done) begin
                sent_words <= '0;  // Next buffer in the ring
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_laddr <= laddr_nxt;
            req_raddr <= raddr_cur;
            req_len   <= chunk_m1[LEN_W-1:0];
        end
    end

endmodule

//--- hdl/rxdma_cpl_track.sv
//////////////////////////////////////////////////////////////////////
// Completion accounting. Frees FIFO bursts as completed words
// cover them and raises one interrupt per finished buffer.
// Totals are modular; only their difference is meaningful.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rxdma_cpl_track (
    input  logic                             clk,
    input  logic                             dma_en,
    input  logic [rxdma_pkg::BURST_W-1:0]    burst_words,
    input  logic                             req_valid,
    input  logic [rxdma_pkg::LEN_W-1:0]      req_len,
    input  logic                             cpl_valid,
    input  logic                             buf_done,
    output logic                             burst_release,
    output logic                             irq
);
    import rxdma_pkg::*;

    logic [LEN_W-1:0]       pend_len;     // Length of the outstanding request
    logic [BUF_WORDS_W-1:0] done_words;
    logic [BUF_WORDS_W-1:0] freed_words;
    logic [BUF_WORDS_W-1:0] held_words;
    logic [BUF_WORDS_W-1:0] burst_ext;
    logic                   can_free;

    assign burst_ext  = BUF_WORDS_W'(burst_words);
    assign held_words = done_words - freed_words;
    assign can_free   = (burst_ext != '0) && (held_words >= burst_ext);

    always_ff @(posedge clk) begin
        if (req_valid) begin
            pend_len <= req_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!dma_en) begin
            done_words    <= '0;
            freed_words   <= '0;
            burst_release <= 1'b0;
            irq           <= 1'b0;
        end else begin
            burst_release <= can_free;  // One burst per cycle at most
            irq           <= buf_done;
            if (cpl_valid) begin
                done_words <= done_words + BUF_WORDS_W'(pend_len) + 1'b1;
            end
            if (can_free) begin
                freed_words <= freed_words + burst_ext;
            end
        end
    end

endmodule

//--- hdl/rxdma_top.sv
//////////////////////////////////////////////////////////////////////
// Receive DMA engine top level. All strobes are single-cycle with
// no back-pressure; the host accepts every request it is given.
// Configuration is only valid while the DMA is stopped.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rxdma_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             reg_valid,
    input  logic [7:0]                       reg_addr,
    input  rxdma_pkg::rxdma_wdata_u          reg_wdata,
    input  logic                             ctrl_valid,
    input  logic                             ctrl_start,
    input  logic [1:0]                       cfg_max_payload_sz,
    input  logic                             burst_fill,
    output logic                             burst_release,
    output logic                             req_valid,
    output logic [rxdma_pkg::LADDR_W-1:0]    req_laddr,
    output logic [rxdma_pkg::RADDR_W-1:0]    req_raddr,
    output logic [rxdma_pkg::LEN_W-1:0]      req_len,
    input  logic                             cpl_valid,
    input  logic                             confirm_valid,
    output logic                             irq,
    output logic                             dma_active
);
    import rxdma_pkg::*;

    logic                   dma_en;
    logic [BURST_W-1:0]     burst_words;
    logic [BPB_W-1:0]       bufs_bursts;
    logic                   tbl_we;
    logic [BUF_IDX_W-1:0]   tbl_idx;
    logic [PAGE_W-1:0]      tbl_page;
    logic [BUF_WORDS_W-1:0] avail_words;
    logic                   buf_complete;
    logic                   host_free;
    logic [PAGE_W-1:0]      cur_page;
    logic                   buf_done;

    assign dma_active = dma_en;

    rxdma_reg_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .reg_valid   (reg_valid),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .ctrl_valid  (ctrl_valid),
        .ctrl_start  (ctrl_start),
        .dma_en      (dma_en),
        .burst_words (burst_words),
        .bufs_bursts (bufs_bursts),
        .tbl_we      (tbl_we),
        .tbl_idx     (tbl_idx),
        .tbl_page    (tbl_page)
    );

    rxdma_buf_ring u_ring (
        .clk           (clk),
        .dma_en        (dma_en),
        .burst_words   (burst_words),
        .bufs_bursts   (bufs_bursts),
        .tbl_we        (tbl_we),
        .tbl_idx       (tbl_idx),
        .tbl_page      (tbl_page),
        .burst_fill    (burst_fill),
        .buf_done      (buf_done),
        .confirm_valid (confirm_valid),
        .avail_words   (avail_words),
        .buf_complete  (buf_complete),
        .host_free     (host_free),
        .cur_page      (cur_page)
    );

    rxdma_req_engine u_engine (
        .clk                (clk),
        .dma_en             (dma_en),
        .cfg_max_payload_sz (cfg_max_payload_sz),
        .avail_words        (avail_words),
        .buf_complete       (buf_complete),
        .host_free          (host_free),
        .cur_page           (cur_page),
        .cpl_valid          (cpl_valid),
        .req_valid          (req_valid),
        .req_laddr          (req_laddr),
        .req_raddr          (req_raddr),
        .req_len            (req_len),
        .buf_done           (buf_done)
    );

    rxdma_cpl_track u_cpl (
        .clk           (clk),
        .dma_en        (dma_en),
        .burst_words   (burst_words),
        .req_valid     (req_valid),
        .req_len       (req_len),
        .cpl_valid     (cpl_valid),
        .buf_done      (buf_done),
        .burst_release (burst_release),
        .irq           (irq)
    );

endmodule

//--- tb/rxdma_properties.sv
//////////////////////////////////////////////////////////////////////
// Strobe rules of the receive DMA, bound to rxdma_top.
// Assumes the host completes requests in order, one at a time.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rxdma_properties (
    input logic                          clk,
    input logic                          rst,
    input logic                          req_valid,
    input logic [rxdma_pkg::LEN_W-1:0]   req_len,
    input logic                          cpl_valid,
    input logic                          irq,
    input logic                          burst_release,
    input logic                          dma_active,
    input logic [1:0]                    cfg_max_payload_sz
);
    import rxdma_pkg::*;

    logic             outstanding;  // A request waits for its completion
    logic [LEN_W:0]   max_words;

    assign max_words = (LEN_W+1)'(8) << cfg_max_payload_sz;

    always_ff @(posedge clk) begin
        if (rst || !dma_active) begin
            outstanding <= 1'b0;
        end else if (req_valid) begin
            outstanding <= 1'b1;
        end else if (cpl_valid) begin
            outstanding <= 1'b0;
        end
    end

    a_single_req: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !outstanding)
        else $error("Request issued while another is outstanding");

    a_irq_after_cpl: assert property (@(posedge clk) disable iff (rst)
        irq |-> $past(cpl_valid))
        else $error("Interrupt without a completion in the cycle before");

    a_quiet_when_off: assert property (@(posedge clk) disable iff (rst)
        !dma_active |-> !(req_valid || irq || burst_release))
        else $error("Strobe seen while the DMA is inactive");

    a_len_max: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> ({1'b0, req_len} < max_words))
        else $error("Request longer than the maximum payload");

endmodule

bind rxdma_top rxdma_properties u_props (.*);

//--- tb/rxdma_tb.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the receive DMA engine.
// The host model completes every request after 1 to 8 cycles.
// Outputs are sampled on the falling edge, inputs change on rising.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rxdma_tb;
    import rxdma_pkg::*;

    // About 40 buffers at under 20 cycles each plus setup; wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 reg_valid;
    logic [7:0]           reg_addr;
    rxdma_wdata_u         reg_wdata;
    logic                 ctrl_valid;
    logic                 ctrl_start;
    logic [1:0]           cfg_max_payload_sz;
    logic                 burst_fill;
    logic                 burst_release;
    logic                 req_valid;
    logic [LADDR_W-1:0]   req_laddr;
    logic [RADDR_W-1:0]   req_raddr;
    logic [LEN_W-1:0]     req_len;
    logic                 cpl_valid = 1'b0;
    logic                 confirm_valid;
    logic                 irq;
    logic                 dma_active;

    integer      seed = 63459;
    int          cpl_wait = 0;
    int          cycle_cnt = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_req = 0;
    int          n_cpl = 0;
    int          n_rel = 0;
    int          n_irq = 0;
    int          n_fill = 0;
    int          n_bufs = 0;
    logic [31:0] laddr_q[$];  // Logged requests, in issue order
    logic [31:0] raddr_q[$];
    logic [31:0] len_q[$];

    rxdma_top DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // Host model, one completion per request after a random delay
    always @(posedge clk) begin
        cpl_valid <= 1'b0;
        if (cpl_wait != 0) begin
            cpl_wait <= cpl_wait - 1;
            if (cpl_wait == 1) cpl_valid <= 1'b1;
        end
        if (req_valid) cpl_wait <= 1 + int'($unsigned($random(seed)) % 8);
    end

    always @(negedge clk) begin
        if (req_valid) begin
            laddr_q.push_back(32'(req_laddr));
            raddr_q.push_back(32'(req_raddr));
            len_q.push_back(32'(req_len));
            n_req++;
            $display("req laddr 0x%0h raddr 0x%0h len %0d", req_laddr, req_raddr, req_len);
        end
        if (cpl_valid) n_cpl++;
        if (burst_release) begin
            n_rel++;
            $display("burst release %0d", n_rel);
        end
        if (irq) begin
            n_irq++;
            $display("irq %0d", n_irq);
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    // Spreads the page over every index bit
    function automatic logic [PAGE_W-1:0] page_of(input int idx);
        return 20'h80000 + PAGE_W'(idx * 257);
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_valid <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_valid <= 1'b0;
    endtask

    task automatic send_ctrl(input logic start);
        @(posedge clk);
        ctrl_valid <= 1'b1;
        ctrl_start <= start;
        @(posedge clk);
        ctrl_valid <= 1'b0;
    endtask

    task automatic configure(input int burst, input int bufs, input logic [1:0] code);
        write_reg({REG_BURST, 5'd0}, 32'(burst));
        write_reg({REG_BPB, 5'd0}, 32'(bufs - 1) << BURST_W);  // Field holds count minus one
        @(posedge clk);
        cfg_max_payload_sz <= code;
    endtask

    task automatic push_bursts(input int bursts, input int bufs);
        repeat (bursts) begin
            @(posedge clk);
            burst_fill <= 1'b1;
        end
        @(posedge clk);
        burst_fill <= 1'b0;
        n_fill += bursts;
        n_bufs += bufs;
    endtask

    // Waits until every request, release and interrupt has come back
    task automatic drain();
        while (n_req != n_cpl || n_rel < n_fill || n_irq < n_bufs) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic check_idle(input string name);
        check(name, 32'd0, 32'(req_valid));
        check(name, 32'd0, 32'(irq));
        check(name, 32'd0, 32'(burst_release));
        check(name, 32'd0, 32'(dma_active));
    endtask

    task automatic reset_quiet();
        for (int i = 0; i < 15; i++) begin
            @(negedge clk);
            if (i >= 2) check_idle("reset held");
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle("after reset");
        end
    endtask

    task automatic payload_chunking();
        int base;
        int irq_base;
        base = n_req;
        irq_base = n_irq;
        configure(16, 2, 2'd0);
        write_reg({REG_ADDR_TBL, 5'd0}, {20'h12345, 12'h000});
        send_ctrl(1'b1);
        push_bursts(2, 1);
        drain();
        check("chunking count", 32'd4, 32'(n_req - base));
        for (int i = 0; i < 4; i++) begin
            check("chunking laddr", 32'(i * 8), laddr_q[base + i]);
            check("chunking raddr", (32'h12345 << 8) + 32'(i * 8), raddr_q[base + i]);
            check("chunking len", 32'd7, len_q[base + i]);
        end
        check("chunking irq", 32'd1, 32'(n_irq - irq_base));
    endtask

    task automatic short_final_chunk();
        int base;
        base = n_req;
        send_ctrl(1'b0);
        configure(20, 2, 2'd2);
        send_ctrl(1'b1);
        push_bursts(2, 1);
        drain();
        check("short count", 32'd2, 32'(n_req - base));
        check("short len 0", 32'd31, len_q[base]);
        check("short len 1", 32'd7, len_q[base + 1]);
        check("short laddr 0", 32'd0, laddr_q[base]);
        check("short laddr 1", 32'd32, laddr_q[base + 1]);
        check("short raddr 1", (32'h12345 << 8) + 32'd32, raddr_q[base + 1]);
    endtask

    task automatic release_accounting();
        check("release count", 32'(n_fill), 32'(n_rel));
        check("irq count", 32'(n_bufs), 32'(n_irq));
    endtask

    task automatic host_flow_control();
        int base;
        int irq_base;
        int i;
        send_ctrl(1'b0);
        configure(8, 1, 2'd0);
        for (i = 0; i < 32; i++) begin
            write_reg({REG_ADDR_TBL, 5'(i)}, {page_of(i), 12'h000});
        end
        base = n_req;
        irq_base = n_irq;
        send_ctrl(1'b1);
        push_bursts(33, 33);
        while (n_irq < irq_base + 32) @(posedge clk);
        repeat (40) @(posedge clk);  // Long enough for a blocked request to show
        check("flow held requests", 32'd32, 32'(n_req - base));
        check("flow held irqs", 32'd32, 32'(n_irq - irq_base));
        @(posedge clk);
        confirm_valid <= 1'b1;
        @(posedge clk);
        confirm_valid <= 1'b0;
        while (n_req < base + 33) @(posedge clk);
        check("flow wrap raddr", 32'(page_of(0)) << 8, raddr_q[base + 32]);
        check("flow wrap laddr", 32'd256, laddr_q[base + 32]);
        drain();
        for (i = 0; i < 32; i++) begin
            check("flow raddr", 32'(page_of(i)) << 8, raddr_q[base + i]);
        end
    endtask

    task automatic stop_restart();
        int base;
        send_ctrl(1'b0);
        @(negedge clk);
        check("stop dma_active", 32'd0, 32'(dma_active));
        base = n_req;
        send_ctrl(1'b1);
        @(negedge clk);
        check("start dma_active", 32'd1, 32'(dma_active));
        push_bursts(1, 1);
        drain();
        check("restart count", 32'd1, 32'(n_req - base));
        check("restart raddr", 32'(page_of(0)) << 8, raddr_q[base]);
        check("restart laddr", 32'd0, laddr_q[base]);
    endtask

    initial begin
        rst = 1'b1;
        reg_valid = 1'b0;
        reg_addr = 8'd0;
        reg_wdata = 32'd0;
        ctrl_valid = 1'b0;
        ctrl_start = 1'b0;
        cfg_max_payload_sz = 2'd0;
        burst_fill = 1'b0;
        confirm_valid = 1'b0;

        reset_quiet();
        payload_chunking();
        short_final_chunk();
        release_accounting();
        host_flow_control();
        stop_restart();
        release_accounting();

        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/rxdma_pkg.sv
hdl/rxdma_reg_decode.sv
hdl/rxdma_buf_ring.sv
hdl/rxdma_req_engine.sv
hdl/rxdma_cpl_track.sv
hdl/rxdma_top.sv
tb/rxdma_properties.sv
tb/rxdma_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the receive DMA testbench with Verilator.
# The result is taken from the simulation log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rxdma_tb \
    -f src.f -Mdir obj_dir -o rxdma_sim

./obj_dir/rxdma_sim 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
